// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_cpu
FILELIST  := sources.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP)
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard src/*.sv src/*.svh verif/*.sv) $(FILELIST)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== sources.f ====
+incdir+src
src/cpu_pkg.sv
src/axi_pkg.sv
src/fetch_ctrl_regs.sv
src/fetch_unit.sv
src/axi_interface.sv
src/cpu.sv
verif/cpu_assertions.sv
verif/tb_cpu.sv

// ==== src/axi_interface.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module axi_interface (
   input  logic                  aclk,
   input  logic                  aresetn,
   // ar
   output logic [`Larid   -1:0]  arid,
   output logic [`Laraddr -1:0]  araddr,
   output logic [`Larlen  -1:0]  arlen,
   output logic [`Larsize -1:0]  arsize,
   output logic [`Larburst-1:0]  arburst,
   output logic [`Larlock -1:0]  arlock,
   output logic [`Larcache-1:0]  arcache,
   output logic [`Larprot -1:0]  arprot,
   output logic                  arvalid,
   input  logic                  arready,
   // r
   input  logic [`Lrid    -1:0]  rid,
   input  logic [`Lrdata  -1:0]  rdata,
   input  logic [`Lrresp  -1:0]  rresp,
   input  logic                  rlast,
   input  logic                  rvalid,
   output logic                  rready,
   // aw
   output logic [`Lawid   -1:0]  awid,
   output logic [`Lawaddr -1:0]  awaddr,
   output logic [`Lawlen  -1:0]  awlen,
   output logic [`Lawsize -1:0]  awsize,
   output logic [`Lawburst-1:0]  awburst,
   output logic [`Lawlock -1:0]  awlock,
   output logic [`Lawcache-1:0]  awcache,
   output logic [`Lawprot -1:0]  awprot,
   output logic                  awvalid,
   input  logic                  awready,
   // w
   output logic [`Lwid    -1:0]  wid,
   output logic [`Lwdata  -1:0]  wdata,
   output logic [`Lwstrb  -1:0]  wstrb,
   output logic                  wlast,
   output logic                  wvalid,
   input  logic                  wready,
   // b
   input  logic [`Lbid    -1:0]  bid,
   input  logic [`Lbresp  -1:0]  bresp,
   input  logic                  bvalid,
   output logic                  bready,
   // instruction side
   input  logic                  inst_req,
   input  cpu_pkg::word_t        inst_addr,
   output logic                  inst_addr_ok,
   output logic                  inst_valid_f,
   output cpu_pkg::word_t        inst_rdata_f,
   // data side
   input  logic                  data_req,
   input  logic                  data_wr,
   input  cpu_pkg::word_t        data_addr,
   input  cpu_pkg::wstrb_t       data_wstrb,
   input  cpu_pkg::word_t        data_wdata,
   output logic                  data_addr_ok,
   output logic                  data_data_ok_m,
   output cpu_pkg::word_t        data_rdata_m,
   output logic                  data_resp_err
);

   axi_pkg::bridge_state_t state;
   axi_pkg::bridge_state_t state_nxt;
   axi_pkg::axi_id_t       id_q;
   cpu_pkg::word_t         addr_q;
   cpu_pkg::word_t         wdata_q;
   cpu_pkg::word_t         rdata_q;
   cpu_pkg::wstrb_t        wstrb_q;
   logic                   aw_done;
   logic                   w_done;
   logic                   take_data;
   logic                   take_inst;
   logic                   ar_fire;
   logic                   r_fire;
   logic                   aw_fire;
   logic                   w_fire;
   logic                   b_fire;
   logic                   inst_ok_q;
   logic                   data_ok_q;
   logic                   resp_err_q;

   // data wins over instructions
   assign take_data = (state == axi_pkg::b_idle) && data_req;
   assign take_inst = (state == axi_pkg::b_idle) && !data_req && inst_req;

   assign ar_fire = arvalid && arready;
   assign r_fire  = rvalid && rready;
   assign aw_fire = awvalid && awready;
   assign w_fire  = wvalid && wready;
   assign b_fire  = bvalid && bready;

   always_comb begin
      state_nxt = state;
      case (state)
         axi_pkg::b_idle: begin
            if (take_data) begin
               state_nxt = data_wr ? axi_pkg::b_aw_w : axi_pkg::b_ar;
            end else if (take_inst) begin
               state_nxt = axi_pkg::b_ar;
            end
         end
         axi_pkg::b_ar: begin
            if (ar_fire) begin
               state_nxt = axi_pkg::b_r;
            end
         end
         axi_pkg::b_r: begin
            if (r_fire) begin
               state_nxt = axi_pkg::b_idle;
            end
         end
         axi_pkg::b_aw_w: begin
            // aw and w may complete in either order
            if ((aw_done || aw_fire) && (w_done || w_fire)) begin
               state_nxt = axi_pkg::b_b;
            end
         end
         axi_pkg::b_b: begin
            if (b_fire) begin
               state_nxt = axi_pkg::b_idle;
            end
         end
         default: begin
            state_nxt = axi_pkg::b_idle;
         end
      endcase
   end

   always_ff @(posedge aclk or negedge aresetn) begin
      if (!aresetn) begin
         state      <= axi_pkg::b_idle;
         aw_done    <= 1'b0;
         w_done     <= 1'b0;
         inst_ok_q  <= 1'b0;
         data_ok_q  <= 1'b0;
         resp_err_q <= 1'b0;
      end else begin
         state <= state_nxt;
         if (state == axi_pkg::b_aw_w && state_nxt != axi_pkg::b_aw_w) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
         end else begin
            if (aw_fire) begin
               aw_done <= 1'b1;
            end
            if (w_fire) begin
               w_done <= 1'b1;
            end
         end
         // return pulses, steered by the id of the beat
         inst_ok_q  <= r_fire && (rid != axi_pkg::id_data);
         data_ok_q  <= (r_fire && (rid == axi_pkg::id_data)) || b_fire;
         // a lone beat must be last, a write response must echo our id
         resp_err_q <= (r_fire && (rresp != axi_pkg::resp_okay || !rlast)) ||
                       (b_fire && (bresp != axi_pkg::resp_okay || bid != id_q));
      end
   end

   // request capture and returned read data
   always_ff @(posedge aclk) begin
      if (take_data) begin
         id_q    <= axi_pkg::id_data;
         addr_q  <= data_addr;
         wdata_q <= data_wdata;
         wstrb_q <= data_wstrb;
      end else if (take_inst) begin
         id_q   <= axi_pkg::id_inst;
         addr_q <= inst_addr;
      end
      if (r_fire) begin
         rdata_q <= rdata;
      end
   end

   // read channels, single beat of 4 bytes, incr burst
   assign arid    = id_q;
   assign araddr  = addr_q;
   assign arlen   = '0;
   assign arsize  = 3'd2;
   assign arburst = 2'b01;
   assign arlock  = '0;
   assign arcache = '0;
   assign arprot  = '0;
   assign arvalid = (state == axi_pkg::b_ar);
   assign rready  = (state == axi_pkg::b_r);

   // write channels, aw and w rise together
   assign awid    = id_q;
   assign awaddr  = addr_q;
   assign awlen   = '0;
   assign awsize  = 3'd2;
   assign awburst = 2'b01;
   assign awlock  = '0;
   assign awcache = '0;
   assign awprot  = '0;
   assign awvalid = (state == axi_pkg::b_aw_w) && !aw_done;
   assign wid     = id_q;
   assign wdata   = wdata_q;
   assign wstrb   = wstrb_q;
   assign wlast   = 1'b1;
   assign wvalid  = (state == axi_pkg::b_aw_w) && !w_done;
   assign bready  = (state == axi_pkg::b_b);

   // core side
   assign inst_addr_ok   = take_inst;
   assign data_addr_ok   = take_data;
   assign inst_valid_f   = inst_ok_q;
   assign inst_rdata_f   = rdata_q;
   assign data_data_ok_m = data_ok_q;
   assign data_rdata_m   = rdata_q;
   assign data_resp_err  = data_ok_q && resp_err_q;

endmodule

// ==== src/axi_pkg.sv ====
`include "cpu_defines.svh"

package axi_pkg;

   typedef logic [`Larid-1:0]  axi_id_t;
   typedef logic [`Lrresp-1:0] axi_resp_t;

   // response codes, exokay and decerr are never produced here
   localparam axi_resp_t resp_okay   = 2'b00;
   localparam axi_resp_t resp_slverr = 2'b10;

   // one id per request source
   localparam axi_id_t id_inst = 4'd0;
   localparam axi_id_t id_data = 4'd1;

   // bridge states, one transaction at a time
   typedef enum logic [2:0] {
      b_idle,
      b_ar,
      b_r,
      b_aw_w,
      b_b
   } bridge_state_t;

endpackage

// ==== src/cpu.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu (
   input  logic                  clk,
   input  logic                  arst_n,
   // configuration port
   input  logic                  cfg_we,
   input  logic [1:0]            cfg_addr,
   input  cpu_pkg::word_t        cfg_wdata,
   output cpu_pkg::word_t        cfg_rdata,
   // load/store port from the execute stage
   input  logic                  data_req,
   input  logic                  data_wr,
   input  cpu_pkg::word_t        data_addr,
   input  cpu_pkg::wstrb_t       data_wstrb,
   input  cpu_pkg::word_t        data_wdata,
   output logic                  data_addr_ok,
   output logic                  data_data_ok_m,
   output cpu_pkg::word_t        data_rdata_m,
   output logic                  data_resp_err,
   // instruction stream
   output logic                  inst_valid_f,
   output cpu_pkg::word_t        inst_rdata_f,
   output cpu_pkg::word_t        inst_addr,
   output logic                  fetch_done,
   // ar
   output logic [`Larid   -1:0]  arid,
   output logic [`Laraddr -1:0]  araddr,
   output logic [`Larlen  -1:0]  arlen,
   output logic [`Larsize -1:0]  arsize,
   output logic [`Larburst-1:0]  arburst,
   output logic [`Larlock -1:0]  arlock,
   output logic [`Larcache-1:0]  arcache,
   output logic [`Larprot -1:0]  arprot,
   output logic                  arvalid,
   input  logic                  arready,
   // r
   input  logic [`Lrid    -1:0]  rid,
   input  logic [`Lrdata  -1:0]  rdata,
   input  logic [`Lrresp  -1:0]  rresp,
   input  logic                  rlast,
   input  logic                  rvalid,
   output logic                  rready,
   // aw
   output logic [`Lawid   -1:0]  awid,
   output logic [`Lawaddr -1:0]  awaddr,
   output logic [`Lawlen  -1:0]  awlen,
   output logic [`Lawsize -1:0]  awsize,
   output logic [`Lawburst-1:0]  awburst,
   output logic [`Lawlock -1:0]  awlock,
   output logic [`Lawcache-1:0]  awcache,
   output logic [`Lawprot -1:0]  awprot,
   output logic                  awvalid,
   input  logic                  awready,
   // w
   output logic [`Lwid    -1:0]  wid,
   output logic [`Lwdata  -1:0]  wdata,
   output logic [`Lwstrb  -1:0]  wstrb,
   output logic                  wlast,
   output logic                  wvalid,
   input  logic                  wready,
   // b
   input  logic [`Lbid    -1:0]  bid,
   input  logic [`Lbresp  -1:0]  bresp,
   input  logic                  bvalid,
   output logic                  bready
);

   cpu_pkg::word_t        boot_pc;
   logic                  fetch_en;
   cpu_pkg::fetch_count_t fetch_limit;
   cpu_pkg::fetch_count_t fetch_count;
   logic                  inst_req;
   logic                  inst_addr_ok;

   fetch_ctrl_regs u_fetch_ctrl_regs (
      .clk         (clk),
      .arst_n      (arst_n),
      .cfg_we      (cfg_we),
      .cfg_addr    (cfg_addr),
      .cfg_wdata   (cfg_wdata),
      .cfg_rdata   (cfg_rdata),
      .fetch_count (fetch_count),
      .boot_pc     (boot_pc),
      .fetch_en    (fetch_en),
      .fetch_limit (fetch_limit)
   );

   // last fetched word stays internal until decode exists
   fetch_unit u_fetch_unit (
      .clk          (clk),
      .arst_n       (arst_n),
      .boot_pc      (boot_pc),
      .fetch_en     (fetch_en),
      .fetch_limit  (fetch_limit),
      .inst_addr_ok (inst_addr_ok),
      .inst_valid_f (inst_valid_f),
      .inst_rdata_f (inst_rdata_f),
      .inst_req     (inst_req),
      .inst_addr    (inst_addr),
      .fetch_count  (fetch_count),
      .fetch_done   (fetch_done),
      .fetched_inst ()
   );

   // every other bridge port matches a top level name
   axi_interface u_axi_interface (
      .aclk    (clk),
      .aresetn (arst_n),
      .*
   );

endmodule

// ==== src/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// core word
`define GRLEN    32

// read address channel
`define Larid    4
`define Laraddr  32
`define Larlen   4
`define Larsize  3
`define Larburst 2
`define Larlock  2
`define Larcache 4
`define Larprot  3

// read data channel
`define Lrid     4
`define Lrdata   32
`define Lrresp   2

// write address channel
`define Lawid    4
`define Lawaddr  32
`define Lawlen   4
`define Lawsize  3
`define Lawburst 2
`define Lawlock  2
`define Lawcache 4
`define Lawprot  3

// write data and response channels
`define Lwid     4
`define Lwdata   32
`define Lwstrb   4
`define Lbid     4
`define Lbresp   2

`endif

// ==== src/cpu_pkg.sv ====
`include "cpu_defines.svh"

package cpu_pkg;

   // address or data word on the core side
   typedef logic [`GRLEN-1:0] word_t;

   // one enable bit per byte lane
   typedef logic [3:0] wstrb_t;

   // number of instructions returned since the last enable
   typedef logic [15:0] fetch_count_t;

   // fetch engine states
   typedef enum logic [1:0] {
      f_idle,
      f_req,
      f_wait,
      f_done
   } fetch_state_t;

endpackage

// ==== src/fetch_ctrl_regs.sv ====
`timescale 1ns/1ps

module fetch_ctrl_regs (
   input  logic                  clk,
   input  logic                  arst_n,
   // configuration port
   input  logic                  cfg_we,
   input  logic [1:0]            cfg_addr,
   input  cpu_pkg::word_t        cfg_wdata,
   output cpu_pkg::word_t        cfg_rdata,
   // fetch unit control
   input  cpu_pkg::fetch_count_t fetch_count,
   output cpu_pkg::word_t        boot_pc,
   output logic                  fetch_en,
   output cpu_pkg::fetch_count_t fetch_limit
);

   // register writes
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         boot_pc     <= '0;
         fetch_en    <= 1'b0;
         fetch_limit <= '0;
      end else if (cfg_we) begin
         case (cfg_addr)
            2'd0: begin
               boot_pc <= cfg_wdata;
            end
            2'd1: begin
               fetch_en <= cfg_wdata[0];
            end
            2'd2: begin
               fetch_limit <= cfg_wdata[15:0];
            end
            default: begin
               // fetch count is read only
            end
         endcase
      end
   end

   // readback, count is live from the fetch unit
   always_comb begin
      case (cfg_addr)
         2'd0:    cfg_rdata = boot_pc;
         2'd1:    cfg_rdata = cpu_pkg::word_t'(fetch_en);
         2'd2:    cfg_rdata = cpu_pkg::word_t'(fetch_limit);
         default: cfg_rdata = cpu_pkg::word_t'(fetch_count);
      endcase
   end

endmodule

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
   input  logic                  clk,
   input  logic                  arst_n,
   // from the register block
   input  cpu_pkg::word_t        boot_pc,
   input  logic                  fetch_en,
   input  cpu_pkg::fetch_count_t fetch_limit,
   // bridge handshake
   input  logic                  inst_addr_ok,
   input  logic                  inst_valid_f,
   input  cpu_pkg::word_t        inst_rdata_f,
   output logic                  inst_req,
   output cpu_pkg::word_t        inst_addr,
   // status
   output cpu_pkg::fetch_count_t fetch_count,
   output logic                  fetch_done,
   output cpu_pkg::word_t        fetched_inst
);

   cpu_pkg::fetch_state_t state;
   cpu_pkg::fetch_count_t count_nxt;
   logic                  en_q;
   logic                  en_rise;

   // start only when no request is outstanding
   assign en_rise   = fetch_en && !en_q &&
                      (state == cpu_pkg::f_idle || state == cpu_pkg::f_done);
   assign count_nxt = fetch_count + 16'd1;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state       <= cpu_pkg::f_idle;
         en_q        <= 1'b0;
         inst_addr   <= '0;
         fetch_count <= '0;
      end else begin
         en_q <= fetch_en;
         if (en_rise) begin
            inst_addr   <= boot_pc;
            fetch_count <= '0;
            // a zero limit finishes at once
            state       <= (fetch_limit == '0) ? cpu_pkg::f_done : cpu_pkg::f_req;
         end else begin
            case (state)
               cpu_pkg::f_req: begin
                  if (inst_addr_ok) begin
                     state <= cpu_pkg::f_wait;
                  end
               end
               cpu_pkg::f_wait: begin
                  if (inst_valid_f) begin
                     fetch_count <= count_nxt;
                     inst_addr   <= inst_addr + 32'd4;
                     state       <= (count_nxt == fetch_limit) ? cpu_pkg::f_done
                                                               : cpu_pkg::f_req;
                  end
               end
               default: begin
                  state <= state;
               end
            endcase
         end
      end
   end

   // last instruction word seen
   always_ff @(posedge clk) begin
      if (state == cpu_pkg::f_wait && inst_valid_f) begin
         fetched_inst <= inst_rdata_f;
      end
   end

   assign inst_req   = (state == cpu_pkg::f_req);
   assign fetch_done = (state == cpu_pkg::f_done);

endmodule

// ==== verif/cpu_assertions.sv ====
`timescale 1ns/1ps

module cpu_assertions (
   input logic           aclk,
   input logic           aresetn,
   input logic           arvalid,
   input logic           arready,
   input cpu_pkg::word_t araddr,
   input logic           rvalid,
   input logic           rready,
   input logic           awvalid,
   input logic           awready,
   input logic           wvalid,
   input logic           wready,
   input cpu_pkg::word_t wdata,
   input logic           bvalid,
   input logic           bready
);

   // one transaction between address handshake and response
   logic busy;

   always_ff @(posedge aclk or negedge aresetn) begin
      if (!aresetn) begin
         busy <= 1'b0;
      end else if ((rvalid && rready) || (bvalid && bready)) begin
         busy <= 1'b0;
      end else if ((arvalid && arready) || (awvalid && awready)) begin
         busy <= 1'b1;
      end
   end

   a_ar_stable: assert property (@(posedge aclk) disable iff (!aresetn)
      arvalid && !arready |=> arvalid && $stable(araddr))
      else $error("arvalid or araddr changed before arready");

   a_w_stable: assert property (@(posedge aclk) disable iff (!aresetn)
      wvalid && !wready |=> wvalid && $stable(wdata))
      else $error("wvalid or wdata changed before wready");

   // a response channel is ready only for an accepted address, and one at a time
   a_ready_excl: assert property (@(posedge aclk) disable iff (!aresetn)
      (rready || bready) |-> busy && !(rready && bready))
      else $error("rready or bready outside a transaction, or both high together");

   a_single: assert property (@(posedge aclk) disable iff (!aresetn)
      busy |-> !arvalid && !awvalid)
      else $error("new address issued before the previous response");

endmodule

bind axi_interface cpu_assertions u_cpu_assertions (
   .aclk    (aclk),
   .aresetn (aresetn),
   .arvalid (arvalid),
   .arready (arready),
   .araddr  (araddr),
   .rvalid  (rvalid),
   .rready  (rready),
   .awvalid (awvalid),
   .awready (awready),
   .wvalid  (wvalid),
   .wready  (wready),
   .wdata   (wdata),
   .bvalid  (bvalid),
   .bready  (bready)
);

// ==== verif/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;

   // one entry of the data-operation table
   typedef struct packed {
      logic            wr;
      cpu_pkg::word_t  addr;
      cpu_pkg::wstrb_t strb;
      cpu_pkg::word_t  wdata;
      cpu_pkg::word_t  exp;
      logic            err;
   } op_t;

   logic                  clk;
   logic                  arst_n;
   logic                  cfg_we;
   logic [1:0]            cfg_addr;
   cpu_pkg::word_t        cfg_wdata;
   cpu_pkg::word_t        cfg_rdata;
   logic                  data_req;
   logic                  data_wr;
   cpu_pkg::word_t        data_addr;
   cpu_pkg::wstrb_t       data_wstrb;
   cpu_pkg::word_t        data_wdata;
   logic                  data_addr_ok;
   logic                  data_data_ok_m;
   cpu_pkg::word_t        data_rdata_m;
   logic                  data_resp_err;
   logic                  inst_valid_f;
   cpu_pkg::word_t        inst_rdata_f;
   cpu_pkg::word_t        inst_addr;
   logic                  fetch_done;
   axi_pkg::axi_id_t      arid, rid, awid, wid, bid;
   cpu_pkg::word_t        araddr, awaddr, rdata, wdata;
   logic [3:0]            arlen, arcache, awlen, awcache, wstrb;
   logic [2:0]            arsize, arprot, awsize, awprot;
   logic [1:0]            arburst, arlock, awburst, awlock;
   axi_pkg::axi_resp_t    rresp, bresp;
   logic                  arvalid, arready, rlast, rvalid, rready;
   logic                  awvalid, awready, wlast, wvalid, wready, bvalid, bready;

   // slave memory and the reference copy used for expected values
   cpu_pkg::word_t        mem [cpu_pkg::word_t];
   cpu_pkg::word_t        ref_mem [cpu_pkg::word_t];
   op_t                   ops [$];
   cpu_pkg::word_t        fetch_base;
   int                    seen_start;
   int                    inst_seen;

   cpu i_cpu (.*);

   initial clk = 1'b0;
   always #4 clk = ~clk;

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic pause_random();
      repeat ($urandom_range(3, 0)) step();
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("Fail %s: expected %h, actual %h", name, expected, actual);
         $display("Verification failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timeout: no %s within 200 cycles", what);
      $display("Verification failed");
      $fatal(1, "stopping on timeout");
   endtask

   function automatic logic probe(input string name);
      case (name)
         "rready":         return rready;
         "bready":         return bready;
         "data_data_ok_m": return data_data_ok_m;
         "fetch_done":     return fetch_done;
         default:          return 1'b0;
      endcase
   endfunction

   // registered signals only, so reading right after the edge is safe
   task automatic wait_for(input string name);
      int n;
      n = 0;
      while (!probe(name)) begin
         step();
         n++;
         if (n >= 200) begin
            report_timeout(name);
         end
      end
   endtask

   // initial memory content
   function automatic cpu_pkg::word_t init_word(input cpu_pkg::word_t addr);
      return addr ^ 32'hA5A5_0000;
   endfunction

   function automatic cpu_pkg::word_t merge_bytes(input cpu_pkg::word_t old,
                                                  input cpu_pkg::word_t wd,
                                                  input cpu_pkg::wstrb_t strb);
      cpu_pkg::word_t res;
      int             b;
      res = old;
      for (b = 0; b < 4; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = wd[8*b +: 8];
         end
      end
      return res;
   endfunction

   function automatic cpu_pkg::word_t mem_read(input cpu_pkg::word_t addr);
      return mem.exists(addr) ? mem[addr] : init_word(addr);
   endfunction

   function automatic cpu_pkg::word_t ref_read(input cpu_pkg::word_t addr);
      return ref_mem.exists(addr) ? ref_mem[addr] : init_word(addr);
   endfunction

   function automatic axi_pkg::axi_resp_t slave_resp(input cpu_pkg::word_t addr);
      return (addr >= 32'hF000_0000) ? axi_pkg::resp_slverr : axi_pkg::resp_okay;
   endfunction

   task automatic add_op(input logic wr, input cpu_pkg::word_t addr,
                         input cpu_pkg::wstrb_t strb, input cpu_pkg::word_t wd);
      op_t op;
      op.wr    = wr;
      op.addr  = addr;
      op.strb  = strb;
      op.wdata = wd;
      op.err   = (addr >= 32'hF000_0000);
      op.exp   = ref_read(addr);
      if (wr && !op.err) begin
         ref_mem[addr] = merge_bytes(op.exp, wd, strb);
      end
      ops.push_back(op);
   endtask

   task automatic build_table();
      // writes and reads with byte strobes, error region at the end
      add_op(1'b1, 32'h200, 4'hF, 32'h1122_3344);
      add_op(1'b0, 32'h200, 4'h0, 32'h0);
      add_op(1'b1, 32'h204, 4'h3, 32'hDEAD_BEEF);
      add_op(1'b0, 32'h204, 4'h0, 32'h0);
      add_op(1'b1, 32'h200, 4'h8, 32'hAB00_0000);
      add_op(1'b0, 32'h200, 4'h0, 32'h0);
      add_op(1'b0, 32'h208, 4'h0, 32'h0);
      add_op(1'b0, 32'hF000_0010, 4'h0, 32'h0);
      add_op(1'b0, 32'h208, 4'h0, 32'h0);
      add_op(1'b1, 32'hF000_0020, 4'hF, 32'h5555_AAAA);
      add_op(1'b1, 32'h20C, 4'h5, 32'h1234_5678);
      add_op(1'b0, 32'h20C, 4'h0, 32'h0);
      // issued while a fetch runs
      add_op(1'b1, 32'h210, 4'hF, 32'hCAFE_F00D);
      add_op(1'b0, 32'h210, 4'h0, 32'h0);
      add_op(1'b0, 32'h100, 4'h0, 32'h0);
   endtask

   task automatic cfg_write(input logic [1:0] addr, input cpu_pkg::word_t value);
      cfg_we    = 1'b1;
      cfg_addr  = addr;
      cfg_wdata = value;
      step();
      cfg_we    = 1'b0;
   endtask

   // readback is combinational, sample mid cycle
   task automatic cfg_check(input logic [1:0] addr, input cpu_pkg::word_t expected,
                            input string name);
      cfg_addr = addr;
      @(negedge clk);
      check_value(name, expected, cfg_rdata);
      step();
   endtask

   task automatic run_op(input int i);
      op_t   op;
      string name;
      int    n;
      op         = ops[i];
      name       = $sformatf("op %0d", i);
      data_req   = 1'b1;
      data_wr    = op.wr;
      data_addr  = op.addr;
      data_wstrb = op.strb;
      data_wdata = op.wdata;
      n = 0;
      @(negedge clk);
      while (!data_addr_ok) begin
         @(negedge clk);
         n++;
         if (n >= 200) begin
            report_timeout("data_addr_ok");
         end
      end
      step();
      data_req = 1'b0;
      wait_for("data_data_ok_m");
      check_value({name, " resp_err"}, op.err, data_resp_err);
      if (!op.wr && !op.err) begin
         check_value({name, " rdata"}, op.exp, data_rdata_m);
      end
   endtask

   task automatic take_aw(output cpu_pkg::word_t addr, output axi_pkg::axi_id_t id);
      pause_random();
      // single beat of 4 bytes, incr, uncached, always from the data port
      check_value("aw attributes",
                  {axi_pkg::id_data, 4'd0, 3'd2, 2'b01, 2'b00, 4'd0, 3'd0},
                  {awid, awlen, awsize, awburst, awlock, awcache, awprot});
      awready = 1'b1;
      addr    = awaddr;
      id      = awid;
      step();
      awready = 1'b0;
   endtask

   task automatic take_w(output cpu_pkg::word_t wd, output cpu_pkg::wstrb_t strb);
      pause_random();
      check_value("w id and last", {axi_pkg::id_data, 1'b1}, {wid, wlast});
      wready = 1'b1;
      wd     = wdata;
      strb   = wstrb;
      step();
      wready = 1'b0;
   endtask

   // single-beat AXI slave with random back-pressure
   initial begin : axi_slave
      cpu_pkg::word_t   a;
      cpu_pkg::word_t   d;
      cpu_pkg::wstrb_t  s;
      axi_pkg::axi_id_t id;
      arready = 1'b0;
      rvalid  = 1'b0;
      rid     = '0;
      rdata   = '0;
      rresp   = '0;
      rlast   = 1'b0;
      awready = 1'b0;
      wready  = 1'b0;
      bvalid  = 1'b0;
      bid     = '0;
      bresp   = '0;
      forever begin
         step();
         if (arvalid) begin
            pause_random();
            // single beat of 4 bytes, incr, uncached
            check_value("ar attributes", {4'd0, 3'd2, 2'b01, 2'b00, 4'd0, 3'd0},
                        {arlen, arsize, arburst, arlock, arcache, arprot});
            arready = 1'b1;
            a       = araddr;
            id      = arid;
            step();
            arready = 1'b0;
            pause_random();
            rvalid  = 1'b1;
            rlast   = 1'b1;
            rid     = id;
            rresp   = slave_resp(a);
            rdata   = (rresp == axi_pkg::resp_okay) ? mem_read(a) : '0;
            wait_for("rready");
            step();
            rvalid  = 1'b0;
            rlast   = 1'b0;
         end else if (awvalid) begin
            // aw and w accepted in random order
            if ($urandom_range(1, 0) == 1) begin
               take_aw(a, id);
               take_w(d, s);
            end else begin
               take_w(d, s);
               take_aw(a, id);
            end
            if (slave_resp(a) == axi_pkg::resp_okay) begin
               mem[a] = merge_bytes(mem_read(a), d, s);
            end
            pause_random();
            bvalid = 1'b1;
            bid    = id;
            bresp  = slave_resp(a);
            wait_for("bready");
            step();
            bvalid = 1'b0;
         end
      end
   end

   // instruction stream must follow base + 4k with no gap
   initial begin : inst_monitor
      cpu_pkg::word_t pc;
      inst_seen = 0;
      forever begin
         step();
         if (inst_valid_f) begin
            pc = fetch_base + (inst_seen - seen_start) * 4;
            check_value("inst addr", pc, inst_addr);
            check_value("inst data", init_word(pc), inst_rdata_f);
            inst_seen++;
         end
      end
   end

   initial begin : main
      int i;
      void'($urandom(32'h41d3bd70));
      arst_n     = 1'b0;
      cfg_we     = 1'b0;
      cfg_addr   = '0;
      cfg_wdata  = '0;
      data_req   = 1'b0;
      data_wr    = 1'b0;
      data_addr  = '0;
      data_wstrb = '0;
      data_wdata = '0;
      fetch_base = '0;
      seen_start = 0;
      build_table();
      repeat (3) @(posedge clk);
      #1;
      arst_n = 1'b1;

      // everything idle after reset
      check_value("reset arvalid", 32'd0, arvalid);
      check_value("reset awvalid", 32'd0, awvalid);
      check_value("reset wvalid", 32'd0, wvalid);
      check_value("reset rready", 32'd0, rready);
      check_value("reset bready", 32'd0, bready);
      check_value("reset inst_req", 32'd0, i_cpu.inst_req);
      check_value("reset data_addr_ok", 32'd0, data_addr_ok);
      check_value("reset data_data_ok_m", 32'd0, data_data_ok_m);
      check_value("reset inst_valid_f", 32'd0, inst_valid_f);
      check_value("reset fetch_done", 32'd0, fetch_done);
      cfg_check(2'd3, 32'd0, "reset fetch count");

      // eight instructions from the boot address
      fetch_base = 32'h100;
      seen_start = inst_seen;
      cfg_write(2'd0, 32'h100);
      cfg_write(2'd2, 32'd8);
      cfg_check(2'd0, 32'h100, "boot_pc readback");
      cfg_check(2'd2, 32'd8, "fetch_limit readback");
      cfg_write(2'd1, 32'd1);
      cfg_check(2'd1, 32'd1, "fetch_en readback");
      wait_for("fetch_done");
      check_value("fetch inst count", 32'd8, inst_seen - seen_start);
      cfg_check(2'd3, 32'd8, "fetch count");
      cfg_write(2'd1, 32'd0);

      // data table, including the error region
      for (i = 0; i < 12; i++) begin
         run_op(i);
      end

      // restart from a new boot address with data traffic mixed in
      fetch_base = 32'h400;
      seen_start = inst_seen;
      cfg_write(2'd0, 32'h400);
      cfg_write(2'd2, 32'd6);
      cfg_write(2'd1, 32'd1);
      step();
      cfg_check(2'd3, 32'd0, "restart fetch count");
      for (i = 12; i < ops.size(); i++) begin
         run_op(i);
      end
      wait_for("fetch_done");
      check_value("restart inst count", 32'd6, inst_seen - seen_start);
      cfg_check(2'd3, 32'd6, "restart fetch count final");

      $display("Verification passed");
      $finish;
   end

endmodule
